// File: adc_cfg_ctrl.f
+incdir+logic
logic/adc_cfg_pkg.sv
logic/adc_spi_shifter.sv
logic/adc_cfg_sequencer.sv
logic/adc_cfg_ctrl.sv
test/adc_cfg_ctrl_chk.sv
test/adc_cfg_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the ADC config testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f adc_cfg_ctrl.f --top-module adc_cfg_ctrl_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vadc_cfg_ctrl_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench prints its verdict on a line of its own
if grep -q "TEST FAIL" "$LOG"; then
  echo "testbench reported failures, see $LOG"
  exit 1
fi

echo "simulation finished without failures"
exit 0

// File: test/adc_cfg_ctrl_tb.sv
// ---------------------------------------------------------------------
// ADC config controller testbench: boot frames, resync pulse and
// random host words checked against a frame queue model
// ---------------------------------------------------------------------
`timescale 1ns/10ps

module adc_cfg_ctrl_tb;

  import adc_cfg_pkg::*;

  localparam int N_HOST  = 40;
  localparam int TIMEOUT = 2000;   // clk cycles per wait loop

  logic      clk;
  logic      rst;
  cfg_req_t  host_req_i;
  logic      host_valid_i;
  logic      host_ready_o;
  adc_pins_t adc_o;
  logic      dcm_reset_o;
  logic      ddrb_o;
  logic      boot_done_o;
  logic      busy_o;

  int          seed;
  int          err_cnt;          // wrong values
  int          fail_cnt;         // timeouts and lost or extra frames
  int          frames_started;   // spi reset strobes seen
  int          frames_done;      // sen_n rises seen
  int          words_taken;      // boot words plus accepted host words
  int          ddrb_pulses;
  int          rst_pulses;       // strobes since the last frame
  int          bit_cnt;
  logic [23:0] rx_word;
  logic [23:0] exp_q[$];         // frames still owed by the DUT
  logic        prev_sclk;
  logic        prev_sen_n;
  logic        prev_spi_rst_n;
  bit          timed_out;        // a wait ran out, rest of the run skipped

  adc_cfg_ctrl #(
    .BOOT_MODE(1)   // dmux 1:2 boot word
  ) UUT (
    .clk         (clk),
    .rst         (rst),
    .host_req_i  (host_req_i),
    .host_valid_i(host_valid_i),
    .host_ready_o(host_ready_o),
    .adc_o       (adc_o),
    .dcm_reset_o (dcm_reset_o),
    .ddrb_o      (ddrb_o),
    .boot_done_o (boot_done_o),
    .busy_o      (busy_o)
  );

  always #2 clk = ~clk;   // 4 ns period

  task automatic check_level(string what, logic got, logic exp);
    if (got !== exp) begin
      $display("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_count(string what, int got, int exp);
    if (got != exp) begin
      $display("ERR %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  // output levels held by reset
  task automatic check_idle_levels();
    check_level("sclk", adc_o.sclk, 1'b0);
    check_level("sdata", adc_o.sdata, 1'b0);
    check_level("sen_n", adc_o.sen_n, 1'b1);
    check_level("spi_rst_n", adc_o.spi_rst_n, 1'b1);
    check_level("dcm_reset_o", dcm_reset_o, 1'b1);
    check_level("ddrb_o", ddrb_o, 1'b0);
    check_level("boot_done_o", boot_done_o, 1'b0);
    check_level("busy_o", busy_o, 1'b0);
    check_level("host_ready_o", host_ready_o, 1'b0);
  endtask

  task automatic end_run();
    $display("value errors: %0d, other failures: %0d", err_cnt, fail_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  endtask

  task automatic check_frame();
    logic [23:0] exp;
    frames_done++;
    check_count("bits in frame", bit_cnt, 24);
    if (exp_q.size() == 0) begin
      $display("frame %h arrived at %0t ns with no word left to send", rx_word, $time);
      fail_cnt++;
    end else begin
      exp = exp_q.pop_front();
      if (rx_word !== exp) begin
        $display("ERR %0t ns: frame %h, expected %h", $time, rx_word, exp);
        err_cnt++;
      end
    end
  endtask

  // model side: every accepted host word owes one frame
  always @(posedge clk) begin
    if (!rst && host_valid_i && host_ready_o) begin
      exp_q.push_back(host_req_i);
      words_taken++;
    end
    if (!rst && host_ready_o && (busy_o || !boot_done_o)) begin
      $display("ERR %0t ns: host_ready_o high while busy or booting", $time);
      err_cnt++;
    end
  end

  // serial port monitor, sdata taken on each sclk rise inside sen_n low
  always @(posedge clk) begin
    if (rst) begin
      prev_sclk      = 1'b0;
      prev_sen_n     = 1'b1;
      prev_spi_rst_n = 1'b1;
    end else begin
      if (ddrb_o) begin
        ddrb_pulses++;
        check_count("frames done at ddrb pulse", frames_done, 2);
      end
      if (prev_spi_rst_n && !adc_o.spi_rst_n) begin
        rst_pulses++;
        frames_started++;
        if (frames_started > words_taken) begin
          $display("frame started at %0t ns without an accepted word", $time);
          fail_cnt++;
        end
      end
      if (prev_sen_n && !adc_o.sen_n) begin
        check_count("spi reset pulses before frame", rst_pulses, 1);
        rst_pulses = 0;
        bit_cnt    = 0;
        rx_word    = '0;
      end
      if (!adc_o.sen_n && adc_o.sclk && !prev_sclk) begin
        rx_word = {rx_word[22:0], adc_o.sdata};   // msb first
        bit_cnt++;
      end
      if (!prev_sen_n && adc_o.sen_n) check_frame();
      prev_sclk      = adc_o.sclk;
      prev_sen_n     = adc_o.sen_n;
      prev_spi_rst_n = adc_o.spi_rst_n;
    end
  end

  task automatic wait_boot_done();
    int n;
    n = 0;
    while (!boot_done_o && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!boot_done_o) begin
      $display("timeout at %0t ns: boot_done_o never rose", $time);
      fail_cnt++;
      timed_out = 1'b1;
    end
  endtask

  // random gap, then hold the word until ready
  task automatic send_word();
    int r;
    int gap;
    int n;
    r   = $random(seed);
    gap = int'(r[15:0] % 16'd6);
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
    r = $random(seed);
    host_req_i.addr = r[7:0];
    host_req_i.data = r[23:8];
    host_valid_i    = 1'b1;
    n = 0;
    while (!host_ready_o && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!host_ready_o) begin
      $display("timeout at %0t ns: host_ready_o never rose", $time);
      fail_cnt++;
      timed_out = 1'b1;
    end else begin
      @(posedge clk);   // word taken on this edge
      #1;
    end
    host_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((frames_done < N_HOST + 2 || busy_o) && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (frames_done < N_HOST + 2 || busy_o) begin
      $display("timeout at %0t ns: only %0d frames came out", $time, frames_done);
      fail_cnt++;
      timed_out = 1'b1;
    end
  endtask

  initial begin
    seed         = 80;
    timed_out    = 1'b0;
    clk          = 1'b0;
    rst          = 1'b1;
    host_req_i   = '0;
    host_valid_i = 1'b0;
    words_taken  = 2;
    exp_q.push_back(24'h810304);   // addr 0x81, dmux 1:2
    exp_q.push_back(24'h820000);
    repeat (4) @(posedge clk);
    #1;
    check_idle_levels();
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    @(posedge clk);
    #1;
    check_idle_levels();
    wait_boot_done();
    if (!timed_out) begin
      check_count("frames done at boot_done_o", frames_done, 2);
      check_count("ddrb pulses", ddrb_pulses, 1);
      check_level("dcm_reset_o", dcm_reset_o, 1'b0);
      for (int i = 0; i < N_HOST && !timed_out; i++) begin
        send_word();
      end
    end
    if (!timed_out) begin
      wait_drain();
    end
    if (!timed_out) begin
      check_count("frames started", frames_started, N_HOST + 2);
      check_count("frames left in model", exp_q.size(), 0);
      check_count("ddrb pulses at end", ddrb_pulses, 1);
    end
    end_run();
  end

endmodule

// File: test/adc_cfg_ctrl_chk.sv
// ---------------------------------------------------------------------
// ADC config controller protocol assertions, bound to the top level
// ---------------------------------------------------------------------
`timescale 1ns/10ps

module adc_cfg_ctrl_chk (
  input logic                   clk,
  input logic                   rst,
  input adc_cfg_pkg::adc_pins_t adc_o,
  input logic                   host_ready_o,
  input logic                   dcm_reset_o,
  input logic                   ddrb_o,
  input logic                   boot_done_o
);

  // mode pin must stay high while the spi reset strobe is low
  a_sen_vs_spi_rst: assert property (@(posedge clk) disable iff (rst)
    !(!adc_o.sen_n && !adc_o.spi_rst_n))
    else $error("sen_n low during spi reset strobe");

  a_ddrb_single: assert property (@(posedge clk) disable iff (rst)
    ddrb_o |=> !ddrb_o)   // resync is a one cycle pulse
    else $error("ddrb_o high for two cycles in a row");

  // host owns the port only once boot is over
  a_ready_after_boot: assert property (@(posedge clk) disable iff (rst)
    host_ready_o |-> boot_done_o)
    else $error("host_ready_o high before boot_done_o");

  a_dcm_stays_low: assert property (@(posedge clk) disable iff (rst)
    boot_done_o |=> !dcm_reset_o)
    else $error("dcm_reset_o raised again after boot");

endmodule

bind adc_cfg_ctrl adc_cfg_ctrl_chk u_chk (
  .clk         (clk),
  .rst         (rst),
  .adc_o       (adc_o),
  .host_ready_o(host_ready_o),
  .dcm_reset_o (dcm_reset_o),
  .ddrb_o      (ddrb_o),
  .boot_done_o (boot_done_o)
);

// File: logic/adc_cfg_ctrl.sv
// ---------------------------------------------------------------------
// ADC config controller top: boot sequencer feeding the serializer
// ---------------------------------------------------------------------
`timescale 1ns/10ps

module adc_cfg_ctrl #(
  parameter int BOOT_MODE = 0   // selects first boot data word
) (
  input  logic                   clk,
  input  logic                   rst,
  input  adc_cfg_pkg::cfg_req_t  host_req_i,
  input  logic                   host_valid_i,
  output logic                   host_ready_o,
  output adc_cfg_pkg::adc_pins_t adc_o,
  output logic                   dcm_reset_o,
  output logic                   ddrb_o,
  output logic                   boot_done_o,
  output logic                   busy_o
);

  import adc_cfg_pkg::*;

  cfg_frame_u frame;         // sequencer to serializer
  logic       frame_valid;
  logic       frame_ready;   // serializer idle

  adc_cfg_sequencer #(
    .BOOT_MODE(BOOT_MODE)
  ) u_seq (
    .clk          (clk),
    .rst          (rst),
    .frame_ready_i(frame_ready),
    .frame_o      (frame),
    .frame_valid_o(frame_valid),
    .host_req_i   (host_req_i),
    .host_valid_i (host_valid_i),
    .host_ready_o (host_ready_o),
    .dcm_reset_o  (dcm_reset_o),
    .ddrb_o       (ddrb_o),
    .boot_done_o  (boot_done_o)
  );

  adc_spi_shifter u_shift (
    .clk          (clk),
    .rst          (rst),
    .frame_i      (frame),
    .frame_valid_i(frame_valid),
    .frame_ready_o(frame_ready),
    .adc_o        (adc_o)
  );

  assign busy_o = !frame_ready;   // frame in flight

endmodule

// File: logic/adc_cfg_sequencer.sv
// ---------------------------------------------------------------------
// ADC config sequencer: power-up settle, boot table playback, clock
// manager release, then host words forwarded to the serializer
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`include "adc_cfg_params.svh"

module adc_cfg_sequencer #(
  parameter int BOOT_MODE = 0   // 0 dmux 1:1, 1 dmux 1:2, 2 ramp test
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    frame_ready_i,   // serializer idle
  output adc_cfg_pkg::cfg_frame_u frame_o,
  output logic                    frame_valid_o,
  input  adc_cfg_pkg::cfg_req_t   host_req_i,
  input  logic                    host_valid_i,
  output logic                    host_ready_o,
  output logic                    dcm_reset_o,
  output logic                    ddrb_o,
  output logic                    boot_done_o
);

  import adc_cfg_pkg::*;

  localparam int SETTLE_W = $clog2(`ADC_CFG_SETTLE_CYCLES);
  localparam logic [SETTLE_W-1:0] SETTLE_LAST = SETTLE_W'(`ADC_CFG_SETTLE_CYCLES - 1);

  // first boot word depends on the converter mode this build targets
  localparam logic [`ADC_CFG_DATA_W-1:0] BOOT_DATA0 =
    (BOOT_MODE == 2) ? `ADC_CFG_BOOT_DATA_RAMP  :
    (BOOT_MODE == 1) ? `ADC_CFG_BOOT_DATA_DMUX2 :
                       `ADC_CFG_BOOT_DATA_DMUX1;

  localparam logic [2:0] ST_SETTLE = 3'd0;   // let the mode line settle
  localparam logic [2:0] ST_LOAD0  = 3'd1;   // offer boot word 0
  localparam logic [2:0] ST_WAIT0  = 3'd2;   // its frame in flight
  localparam logic [2:0] ST_LOAD1  = 3'd3;
  localparam logic [2:0] ST_WAIT1  = 3'd4;
  localparam logic [2:0] ST_RESYNC = 3'd5;   // one cycle ddrb pulse
  localparam logic [2:0] ST_RUN    = 3'd6;   // host owns the serializer

  logic [2:0]          state;
  logic [SETTLE_W-1:0] settle_cnt;
  logic                run;
  cfg_frame_u          boot_frame;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_SETTLE;
      settle_cnt <= '0;
    end else begin
      case (state)
        ST_SETTLE: begin
          if (settle_cnt == SETTLE_LAST) begin
            state <= ST_LOAD0;
          end else begin
            settle_cnt <= settle_cnt + 1'b1;
          end
        end
        ST_LOAD0: begin
          if (frame_ready_i) state <= ST_WAIT0;   // valid is high here, so taken
        end
        ST_WAIT0: begin
          // ready drops right after acceptance and returns after the tail
          if (frame_ready_i) state <= ST_LOAD1;
        end
        ST_LOAD1: begin
          if (frame_ready_i) state <= ST_WAIT1;
        end
        ST_WAIT1: begin
          if (frame_ready_i) state <= ST_RESYNC;
        end
        ST_RESYNC: begin
          state <= ST_RUN;
        end
        ST_RUN: begin
          state <= ST_RUN;   // stays until reset
        end
        default: begin
          state <= ST_SETTLE;
        end
      endcase
    end
  end

  assign run = (state == ST_RUN);

  // boot table, two words
  always_comb begin
    if (state == ST_LOAD1) begin
      boot_frame.fld.addr = `ADC_CFG_BOOT_ADDR1;
      boot_frame.fld.data = `ADC_CFG_BOOT_DATA1;
    end else begin
      boot_frame.fld.addr = `ADC_CFG_BOOT_ADDR0;
      boot_frame.fld.data = BOOT_DATA0;
    end
  end

  // host word goes straight through in run, no extra stage
  always_comb begin
    if (run) begin
      frame_o.fld.addr = host_req_i.addr;
      frame_o.fld.data = host_req_i.data;
    end else begin
      frame_o = boot_frame;
    end
  end

  assign frame_valid_o = (state == ST_LOAD0) || (state == ST_LOAD1) || (run && host_valid_i);
  assign host_ready_o  = run && frame_ready_i;   // busy serializer is the only stall

  assign ddrb_o      = (state == ST_RESYNC);
  assign dcm_reset_o = !run;   // clock manager held until boot is done
  assign boot_done_o = run;

endmodule

// File: logic/adc_spi_shifter.sv
// ---------------------------------------------------------------------
// ADC serializer: divided serial clock and frame FSM that shifts one
// 24-bit word out on the three-wire port, msb first
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`include "adc_cfg_params.svh"

module adc_spi_shifter (
  input  logic                    clk,
  input  logic                    rst,
  input  adc_cfg_pkg::cfg_frame_u frame_i,
  input  logic                    frame_valid_i,
  output logic                    frame_ready_o,   // high only in idle
  output adc_cfg_pkg::adc_pins_t  adc_o
);

  localparam int FRAME_W = `ADC_CFG_FRAME_W;
  localparam int DIV_W   = `ADC_CFG_DIV_BITS;
  localparam int CNT_W   = $clog2(FRAME_W);

  // frame states, all but idle advance on tick
  localparam logic [2:0] ST_IDLE   = 3'd0;   // nothing queued
  localparam logic [2:0] ST_WAIT   = 3'd1;   // spi reset low, align to tick
  localparam logic [2:0] ST_STRB0  = 3'd2;   // one sclk with enable high
  localparam logic [2:0] ST_DATA   = 3'd3;   // 24 sclk periods of data
  localparam logic [2:0] ST_COMMIT = 3'd4;   // enable back high, latch in adc
  localparam logic [2:0] ST_STRB1  = 3'd5;
  localparam logic [2:0] ST_SWAIT  = 3'd6;   // last guard period

  logic [DIV_W-1:0]   div_cnt;   // free running, msb is sclk
  logic               tick;      // falling sclk edge
  logic [FRAME_W-1:0] shift_q;
  logic [CNT_W-1:0]   bit_cnt;   // bits sent in this frame
  logic [2:0]         state;
  logic               accept;

  // divider runs all the time so sclk phase is fixed to clk
  always_ff @(posedge clk) begin
    if (rst) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;   // wraps from all ones
    end
  end

  assign tick   = &div_cnt;
  assign accept = frame_valid_i && frame_ready_o;

  // frame FSM
  // acceptance wins over a tick landing on the same cycle, so the
  // wait state may last up to one extra sclk period
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= ST_IDLE;
      bit_cnt <= '0;
      shift_q <= '0;   // sdata parks low
    end else if (accept) begin
      shift_q <= frame_i.raw;
      bit_cnt <= '0;
      state   <= ST_WAIT;
    end else if (tick) begin
      case (state)
        ST_IDLE: begin
          state <= ST_IDLE;   // hold until a frame arrives
        end
        ST_WAIT: begin
          state <= ST_STRB0;
        end
        ST_STRB0: begin
          state <= ST_DATA;   // msb already on sdata
        end
        ST_DATA: begin
          shift_q <= {shift_q[FRAME_W-2:0], 1'b0};   // next bit at falling edge
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == CNT_W'(FRAME_W - 1)) begin
            state <= ST_COMMIT;   // last bit was sampled on this period
          end
        end
        ST_COMMIT: begin
          state <= ST_STRB1;
        end
        ST_STRB1: begin
          state <= ST_SWAIT;
        end
        ST_SWAIT: begin
          state <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  assign frame_ready_o = (state == ST_IDLE);

  // pins decode straight from the FSM
  always_comb begin
    if (state == ST_IDLE || state == ST_WAIT) begin
      adc_o.sclk = 1'b0;   // clock only runs inside a frame
    end else begin
      adc_o.sclk = div_cnt[DIV_W-1];   // rises mid period, falls on tick
    end
    adc_o.sdata     = shift_q[FRAME_W-1];
    adc_o.sen_n     = (state != ST_DATA);   // enable only around the data bits
    adc_o.spi_rst_n = (state != ST_WAIT);   // reset strobe once per frame
  end

endmodule

// File: logic/adc_cfg_pkg.sv
// ---------------------------------------------------------------------
// ADC config types: serial frame, host request and ADC pin bundle
// ---------------------------------------------------------------------
`include "adc_cfg_params.svh"

package adc_cfg_pkg;

  // register word as seen by the sequencer
  typedef struct packed {
    logic [`ADC_CFG_ADDR_W-1:0] addr;   // shifted first
    logic [`ADC_CFG_DATA_W-1:0] data;
  } cfg_fields_t;

  // one serial frame, written by fields, shifted as raw bits
  typedef union packed {
    logic [`ADC_CFG_FRAME_W-1:0] raw;   // msb leaves first
    cfg_fields_t                 fld;
  } cfg_frame_u;

  // host side write request
  typedef struct packed {
    logic [`ADC_CFG_ADDR_W-1:0] addr;
    logic [`ADC_CFG_DATA_W-1:0] data;
  } cfg_req_t;

  // three-wire port plus the spi reset strobe
  typedef struct packed {
    logic sclk;        // divided serial clock, idles low
    logic sdata;       // changes on falling sclk
    logic sen_n;       // mode pin, low while bits shift
    logic spi_rst_n;   // low pulse ahead of each frame
  } adc_pins_t;

endpackage

// File: logic/adc_cfg_params.svh
// ---------------------------------------------------------------------
// ADC three-wire config constants: frame widths, serial clock divide,
// power-up settle time and the boot table words
// ---------------------------------------------------------------------
`ifndef ADC_CFG_PARAMS_SVH
`define ADC_CFG_PARAMS_SVH

// frame layout, address goes out first
`define ADC_CFG_ADDR_W   8
`define ADC_CFG_DATA_W   16
`define ADC_CFG_FRAME_W  24

// sclk period is 2**DIV_BITS clk cycles
`define ADC_CFG_DIV_BITS 2   // scaled down for sim, hw uses 7

// wait after reset before the first frame, mode line is slow to settle
`define ADC_CFG_SETTLE_CYCLES 64

// boot table addresses
`define ADC_CFG_BOOT_ADDR0 8'h81   // main mode register
`define ADC_CFG_BOOT_ADDR1 8'h82

// first boot word data, picked by BOOT_MODE
`define ADC_CFG_BOOT_DATA_DMUX1 16'h0344   // 2 channel, dmux 1:1
`define ADC_CFG_BOOT_DATA_DMUX2 16'h0304   // 2 channel, dmux 1:2
`define ADC_CFG_BOOT_DATA_RAMP  16'h1344   // ramp test pattern

// second boot word data
`define ADC_CFG_BOOT_DATA1 16'h0000

`endif
